/* sources.f */
+incdir+verilog
verilog/isa_pkg.sv
verilog/sched_pkg.sv
verilog/issue_queue.sv
verilog/reg_file.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/wb_arbiter.sv
verilog/ooo_core.sv
test/ooo_core_tb.sv

/* test/ooo_core_tb.sv */
// testbench for ooo_core with lfsr stimulus, in-order reference model and result checks
`include "ooo_params.svh"

module ooo_core_tb
    import isa_pkg::*;
    import sched_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int A  = `REG_ADDR_W;
    localparam int D  = `DATA_W;
    localparam int TO = 2000;                   // cycles allowed per wait

    logic         clk;
    logic         reset;
    logic         load;
    alu_op_t      op;
    logic [A-1:0] src1;
    logic [A-1:0] src2;
    logic [A-1:0] dst;
    logic         issue;
    logic         host_we;
    logic [A-1:0] host_addr;
    logic [D-1:0] host_data;
    logic         is_full;
    logic         host_busy;
    logic         wb_valid;
    logic [A-1:0] wb_dst;
    logic [D-1:0] wb_data;
    wb_src_t      wb_src;

    logic [31:0]  lfsr_state;
    logic [D-1:0] model    [`REG_NUM];      // architectural state in program order
    logic [D-1:0] exp_data [`REG_NUM];      // expected writeback per destination
    wb_src_t      exp_src  [`REG_NUM];
    bit           busy     [`REG_NUM];      // writeback still outstanding
    bit           is_instr [`REG_NUM];      // 0 for a host write
    int           src_use  [`REG_NUM];      // in-flight readers of a register
    logic [A-1:0] pend_s1  [`REG_NUM];
    logic [A-1:0] pend_s2  [`REG_NUM];
    logic [A-1:0] last_dst;
    int           loads_acc;
    int           instr_wb;
    int           outstanding;
    bit           hold_check;               // no writeback allowed while set

    ooo_core ooo_core_i (
        .clk, .reset, .load, .op, .src1, .src2, .dst, .issue,
        .host_we, .host_addr, .host_data, .is_full, .host_busy,
        .wb_valid, .wb_dst, .wb_data, .wb_src
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_result(input logic [A-1:0] r, input logic [D-1:0] exp_v,
                                input logic [D-1:0] act_v);
        if (act_v !== exp_v) begin
            abort_run($sformatf("FAIL t=%0t wb_data r%0d expected %h got %h",
                                $time, r, exp_v, act_v));
        end
    endtask

    task automatic check_src(input wb_src_t exp_v, input wb_src_t act_v);
        if (act_v !== exp_v) begin
            abort_run($sformatf("FAIL t=%0t wb_src expected %s got %s",
                                $time, exp_v.name(), act_v.name()));
        end
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            abort_run($sformatf("FAIL t=%0t %s expected %b got %b", $time, name, exp_v, act_v));
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    // reference semantics of each opcode
    function automatic logic [D-1:0] model_op(input alu_op_t o, input logic [D-1:0] a,
                                              input logic [D-1:0] b);
        case (o)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? D'(1) : D'(0);
            OP_MUL:  return a * b;              // low half of the product
            default: return '0;
        endcase
    endfunction

    // free destination that is not busy and read by nothing in flight
    function automatic logic [A-1:0] pick_dst();
        logic [A-1:0] start;
        logic [A-1:0] r;
        start = A'(rand_bits(A));
        for (int k = 0; k < `REG_NUM; k++) begin
            r = start + A'(k);
            if ((r != '0) && !busy[r] && (src_use[r] == 0)) return r;
        end
        return '0;
    endfunction

    function automatic logic [A-1:0] pick_src(input bit dep);
        logic [A-1:0] start;
        logic [A-1:0] r;
        if (dep && rand_bits(1)) return last_dst;   // chain on the latest result
        start = A'(rand_bits(A));
        if (dep) return start;
        for (int k = 0; k < `REG_NUM; k++) begin
            r = start + A'(k);
            if (!busy[r]) return r;
        end
        return '0;
    endfunction

    // called right after a falling edge
    task automatic send_instr(input bit dep, output bit taken);
        logic [2:0]   code;
        alu_op_t      o;
        logic [A-1:0] s1;
        logic [A-1:0] s2;
        logic [A-1:0] d;
        code = 3'(rand_bits(3));
        o    = (code == 3'd7) ? OP_MUL : alu_op_t'(code);  // two codes of eight are multiplies
        s1   = pick_src(dep);
        s2   = pick_src(dep);
        d    = pick_dst();
        if (d == '0) abort_run("no free destination register for dispatch");
        load  = 1'b1;
        op    = o;
        src1  = s1;
        src2  = s2;
        dst   = d;
        taken = !is_full;                       // is_full is stable until the next rising edge
        if (taken) begin
            exp_data[d] = model_op(o, model[s1], model[s2]);
            model[d]    = exp_data[d];
            exp_src[d]  = (o == OP_MUL) ? WB_MUL : WB_ALU;
            busy[d]     = 1'b1;
            is_instr[d] = 1'b1;
            pend_s1[d]  = s1;
            pend_s2[d]  = s2;
            src_use[s1]++;
            src_use[s2]++;
            last_dst = d;
            loads_acc++;
            outstanding++;
        end
    endtask

    task automatic host_write(input logic [A-1:0] r, input logic [D-1:0] v);
        int cyc;
        cyc = 0;
        while (host_busy) begin
            if (cyc >= TO) abort_run("timeout, host_busy high before a host write");
            @(negedge clk);
            cyc++;
        end
        host_we     = 1'b1;
        host_addr   = r;
        host_data   = v;
        model[r]    = v;
        exp_data[r] = v;
        exp_src[r]  = WB_HOST;
        busy[r]     = 1'b1;
        is_instr[r] = 1'b0;
        outstanding++;
        @(negedge clk);
        host_we = 1'b0;
        check_flag("host_busy", 1'b1, host_busy);   // write now waits in the pending register
        cyc     = 0;
        while (host_busy) begin
            if (cyc >= TO) abort_run("timeout, host_busy did not fall after a host write");
            @(negedge clk);
            cyc++;
        end
    endtask

    task automatic drain_queue();
        int cyc;
        load  = 1'b0;
        issue = 1'b1;
        cyc   = 0;
        while (outstanding != 0) begin
            if (cyc >= TO) abort_run("timeout, instructions never wrote back");
            @(negedge clk);
            cyc++;
        end
        if (instr_wb != loads_acc) begin
            abort_run($sformatf("writeback count %0d differs from accepted loads %0d",
                                instr_wb, loads_acc));
        end
    endtask

    // result bus monitor sampling values as they stand before the edge
    always @(posedge clk) begin
        if (!reset && wb_valid) begin
            if (hold_check) abort_run("writeback seen while issue was held low");
            if (!busy[wb_dst]) begin
                abort_run($sformatf("unexpected writeback to r%0d at t=%0t", wb_dst, $time));
            end
            check_result(wb_dst, exp_data[wb_dst], wb_data);
            check_src(exp_src[wb_dst], wb_src);
            busy[wb_dst] = 1'b0;
            outstanding--;
            if (is_instr[wb_dst]) begin
                src_use[pend_s1[wb_dst]]--;
                src_use[pend_s2[wb_dst]]--;
                instr_wb++;
            end
        end
    end

    initial begin : main_seq
        bit taken;
        int held;
        clk        = 1'b0;
        reset      = 1'b1;
        load       = 1'b0;
        op         = OP_ADD;
        src1       = '0;
        src2       = '0;
        dst        = '0;
        issue      = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_data  = '0;
        lfsr_state = 32'hcaba;
        for (int r = 0; r < `REG_NUM; r++) begin
            model[r]    = '0;
            exp_data[r] = '0;
            exp_src[r]  = WB_NONE;
            busy[r]     = 1'b0;
            is_instr[r] = 1'b0;
            src_use[r]  = 0;
        end
        last_dst    = '0;
        loads_acc   = 0;
        instr_wb    = 0;
        outstanding = 0;
        hold_check  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_flag("is_full", 1'b0, is_full);
        check_flag("host_busy", 1'b0, host_busy);
        check_flag("wb_valid", 1'b0, wb_valid);

        for (int r = 1; r < `REG_NUM; r++) begin   // preload through the host port
            host_write(A'(r), D'(rand_bits(D)));
        end

        issue = 1'b1;                           // independent operations
        for (int i = 0; i < 60; i++) begin
            @(negedge clk);
            send_instr(1'b0, taken);
        end
        @(negedge clk);
        drain_queue();

        for (int i = 0; i < 60; i++) begin      // dependent chains
            @(negedge clk);
            send_instr(1'b1, taken);
        end
        @(negedge clk);
        drain_queue();

        issue      = 1'b0;                      // queue fills under back-pressure and drops the rest
        hold_check = 1'b1;
        held       = 0;
        for (int i = 0; i < `IQ_ENTRIES + 2; i++) begin
            @(negedge clk);
            check_flag("is_full", held == `IQ_ENTRIES, is_full);
            send_instr(1'b1, taken);
            if (taken) held++;
        end
        @(negedge clk);
        load = 1'b0;
        repeat (8) @(negedge clk);              // held entries must stay put
        check_flag("is_full", 1'b1, is_full);
        hold_check = 1'b0;
        drain_queue();

        for (int i = 0; i < 300; i++) begin     // random issue level with a dense mix
            @(negedge clk);
            issue = (rand_bits(2) != 0);
            if (rand_bits(1)) send_instr(rand_bits(1) != 0, taken);
            else              load = 1'b0;
        end
        @(negedge clk);
        drain_queue();
        check_flag("is_full", 1'b0, is_full);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* verilog/ooo_core.sv */
// top level, issue queue, register file, alu, multiplier and writeback arbiter
`include "ooo_params.svh"

module ooo_core
    import isa_pkg::*;
    import sched_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    // dispatch
    input  logic                   load,
    input  alu_op_t                op,
    input  logic [`REG_ADDR_W-1:0] src1,
    input  logic [`REG_ADDR_W-1:0] src2,
    input  logic [`REG_ADDR_W-1:0] dst,
    input  logic                   issue,
    // host register write
    input  logic                   host_we,
    input  logic [`REG_ADDR_W-1:0] host_addr,
    input  logic [`DATA_W-1:0]     host_data,
    output logic                   is_full,
    output logic                   host_busy,
    // result bus
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_dst,
    output logic [`DATA_W-1:0]     wb_data,
    output wb_src_t                wb_src
);

    logic                   issue_valid;
    alu_op_t                iss_op;
    op_class_t              iss_class;
    logic [`REG_ADDR_W-1:0] iss_src1;
    logic [`REG_ADDR_W-1:0] iss_src2;
    logic [`REG_ADDR_W-1:0] iss_dst;
    logic [`DATA_W-1:0]     opa;                // operands read in the issue cycle
    logic [`DATA_W-1:0]     opb;
    logic                   alu_start;
    logic                   mul_start;
    logic                   alu_valid;
    logic [`REG_ADDR_W-1:0] alu_dst;
    logic [`DATA_W-1:0]     alu_data;
    logic                   mul_valid;
    logic [`REG_ADDR_W-1:0] mul_dst;
    logic [`DATA_W-1:0]     mul_data;

    // steer the issue pulse by opcode class
    assign alu_start = issue_valid && (iss_class == CLASS_ALU);
    assign mul_start = issue_valid && (iss_class == CLASS_MUL);

    issue_queue issue_queue_i (
        .clk, .reset, .load, .op, .src1, .src2, .dst, .issue,
        .wb_valid, .wb_dst, .is_full,
        .issue_valid, .iss_op, .iss_class, .iss_src1, .iss_src2, .iss_dst
    );

    reg_file reg_file_i (
        .clk, .reset,
        .rd_addr1 (iss_src1), .rd_addr2 (iss_src2),
        .rd_data1 (opa),      .rd_data2 (opb),
        .we       (wb_valid), .wr_addr  (wb_dst),   .wr_data (wb_data)   // result bus writes
    );

    alu_unit alu_unit_i (
        .clk, .reset, .start (alu_start), .op (iss_op), .dst (iss_dst),
        .a (opa), .b (opb),
        .res_valid (alu_valid), .res_dst (alu_dst), .res_data (alu_data)
    );

    mul_unit mul_unit_i (
        .clk, .reset, .start (mul_start), .dst (iss_dst), .a (opa), .b (opb),
        .res_valid (mul_valid), .res_dst (mul_dst), .res_data (mul_data)
    );

    wb_arbiter wb_arbiter_i (
        .clk, .reset,
        .alu_valid, .alu_dst, .alu_data,
        .mul_valid, .mul_dst, .mul_data,
        .host_we, .host_addr, .host_data,
        .wb_valid, .wb_dst, .wb_data, .wb_src, .host_busy
    );

endmodule

/* verilog/wb_arbiter.sv */
// result bus arbiter for multiplier, alu and pending host write
`include "ooo_params.svh"

module wb_arbiter
    import sched_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   alu_valid,
    input  logic [`REG_ADDR_W-1:0] alu_dst,
    input  logic [`DATA_W-1:0]     alu_data,
    input  logic                   mul_valid,
    input  logic [`REG_ADDR_W-1:0] mul_dst,
    input  logic [`DATA_W-1:0]     mul_data,
    input  logic                   host_we,
    input  logic [`REG_ADDR_W-1:0] host_addr,
    input  logic [`DATA_W-1:0]     host_data,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_dst,
    output logic [`DATA_W-1:0]     wb_data,
    output wb_src_t                wb_src,
    output logic                   host_busy
);

    logic                   host_pend;          // one-entry host write buffer
    logic [`REG_ADDR_W-1:0] host_addr_q;
    logic [`DATA_W-1:0]     host_data_q;
    logic                   mul_req;
    logic                   alu_req;
    logic                   host_req;
    wb_src_t                grant;

    // results for r0 are discards and never reach the bus
    assign mul_req  = mul_valid && (mul_dst != '0);
    assign alu_req  = alu_valid && (alu_dst != '0);
    assign host_req = host_pend && (host_addr_q != '0);

    always_comb begin
        if (mul_req)       grant = WB_MUL;      // fixed priority mul > alu > host
        else if (alu_req)  grant = WB_ALU;
        else if (host_req) grant = WB_HOST;
        else               grant = WB_NONE;
    end

    always_comb begin
        case (grant)
            WB_MUL: begin
                wb_dst  = mul_dst;
                wb_data = mul_data;
            end
            WB_ALU: begin
                wb_dst  = alu_dst;
                wb_data = alu_data;
            end
            WB_HOST: begin
                wb_dst  = host_addr_q;
                wb_data = host_data_q;
            end
            default: begin
                wb_dst  = '0;
                wb_data = '0;
            end
        endcase
    end

    assign wb_valid  = (grant != WB_NONE);
    assign wb_src    = grant;
    assign host_busy = host_pend;

    // pending write leaves once the units leave the bus free
    always_ff @(posedge clk) begin
        if (reset)                              host_pend <= 1'b0;
        else if (host_we)                       host_pend <= 1'b1;
        else if (host_pend && !mul_req && !alu_req) host_pend <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (host_we) begin
            host_addr_q <= host_addr;
            host_data_q <= host_data;
        end
    end

endmodule

/* verilog/mul_unit.sv */
// three-stage pipelined multiplier, low half of the product, tag carried along
`include "ooo_params.svh"

module mul_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic [`REG_ADDR_W-1:0] dst,
    input  logic [`DATA_W-1:0]     a,
    input  logic [`DATA_W-1:0]     b,
    output logic                   res_valid,
    output logic [`REG_ADDR_W-1:0] res_dst,
    output logic [`DATA_W-1:0]     res_data
);

    localparam int H = `DATA_W / 2;             // split b into halves

    logic [`DATA_W-1:0]     pp_lo_c;            // a * b_lo, low bits
    logic [H-1:0]           pp_hi_c;            // a_lo * b_hi, only bits that survive the shift
    logic [`DATA_W-1:0]     s1_lo;
    logic [H-1:0]           s1_hi;
    logic [`DATA_W-1:0]     s2_sum;
    logic [2:0]             vld;                // valid per stage
    logic [`REG_ADDR_W-1:0] s1_dst;
    logic [`REG_ADDR_W-1:0] s2_dst;

    assign pp_lo_c = a * {{H{1'b0}}, b[H-1:0]};
    assign pp_hi_c = a[H-1:0] * b[`DATA_W-1:H];

    always_ff @(posedge clk) begin
        if (reset) vld <= '0;
        else       vld <= {vld[1:0], start};    // three ops can be in flight
    end

    // datapath stages
    always_ff @(posedge clk) begin
        s1_lo    <= pp_lo_c;                    // stage 1, partial products
        s1_hi    <= pp_hi_c;
        s1_dst   <= dst;
        s2_sum   <= s1_lo + {s1_hi, {H{1'b0}}}; // stage 2, combine
        s2_dst   <= s1_dst;
        res_data <= s2_sum;                     // stage 3, output register
        res_dst  <= s2_dst;
    end

    assign res_valid = vld[2];

endmodule

/* verilog/alu_unit.sv */
// one-cycle integer alu with registered result and destination tag
`include "ooo_params.svh"

module alu_unit
    import isa_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,       // issue of an alu-class op
    input  alu_op_t                op,
    input  logic [`REG_ADDR_W-1:0] dst,
    input  logic [`DATA_W-1:0]     a,
    input  logic [`DATA_W-1:0]     b,
    output logic                   res_valid,
    output logic [`REG_ADDR_W-1:0] res_dst,
    output logic [`DATA_W-1:0]     res_data
);

    logic [`DATA_W-1:0] alu_res;

    always_comb begin
        case (op)
            OP_ADD:  alu_res = a + b;
            OP_SUB:  alu_res = a - b;
            OP_AND:  alu_res = a & b;
            OP_OR:   alu_res = a | b;
            OP_XOR:  alu_res = a ^ b;
            OP_SLT:  alu_res = {{(`DATA_W-1){1'b0}}, ($signed(a) < $signed(b))};
            default: alu_res = '0;              // OP_MUL never steered here
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) res_valid <= 1'b0;
        else       res_valid <= start;
    end

    always_ff @(posedge clk) begin
        if (start) begin
            res_dst  <= dst;
            res_data <= alu_res;
        end
    end

endmodule

/* verilog/reg_file.sv */
// register file, two combinational read ports and one write port, r0 fixed to zero
`include "ooo_params.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   reset,
    // operand reads for the issued instruction
    input  logic [`REG_ADDR_W-1:0] rd_addr1,
    input  logic [`REG_ADDR_W-1:0] rd_addr2,
    output logic [`DATA_W-1:0]     rd_data1,
    output logic [`DATA_W-1:0]     rd_data2,
    // single write port, driven by the result bus
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] wr_addr,
    input  logic [`DATA_W-1:0]     wr_data
);

    logic [`DATA_W-1:0] regs [`REG_NUM];

    // no bypass, a write shows up on the reads one cycle later
    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_addr != '0)) begin   // r0 stays zero
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

/* verilog/issue_queue.sv */
// issue queue with ready table, wakeup, oldest-ready select and writeback slot reservation
`include "ooo_params.svh"

module issue_queue
    import isa_pkg::*;
    import sched_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    // dispatch side
    input  logic                   load,
    input  alu_op_t                op,
    input  logic [`REG_ADDR_W-1:0] src1,
    input  logic [`REG_ADDR_W-1:0] src2,
    input  logic [`REG_ADDR_W-1:0] dst,
    input  logic                   issue,       // level, allow one select per cycle
    // result bus snoop
    input  logic                   wb_valid,
    input  logic [`REG_ADDR_W-1:0] wb_dst,
    output logic                   is_full,
    // issued instruction, registered
    output logic                   issue_valid,
    output alu_op_t                iss_op,
    output op_class_t              iss_class,
    output logic [`REG_ADDR_W-1:0] iss_src1,
    output logic [`REG_ADDR_W-1:0] iss_src2,
    output logic [`REG_ADDR_W-1:0] iss_dst
);

    iq_entry_t              entries [`IQ_ENTRIES];
    logic [`REG_NUM-1:0]    ready_table;        // 1 = register value final
    logic [`IQ_IDX_W:0]     count;              // occupied entries, 0..IQ_ENTRIES
    logic [1:0]             mul_hist;           // [0] mul picked last cycle, [1] two cycles ago

    logic [`IQ_ENTRIES-1:0] cand;               // entries eligible this cycle
    logic                   sel_found;
    logic [`IQ_IDX_W-1:0]   sel_idx;
    logic [`IQ_IDX_W-1:0]   sel_age;
    op_class_t              sel_class;
    logic [`IQ_IDX_W-1:0]   free_idx;
    logic                   take_load;
    logic                   take_issue;
    logic [`IQ_IDX_W:0]     load_age;           // post-issue occupancy
    logic                   new_rdy1;
    logic                   new_rdy2;

    assign is_full    = (count == (`IQ_IDX_W+1)'(`IQ_ENTRIES));
    assign take_load  = load && !is_full;       // load while full is dropped
    assign take_issue = issue && sel_found;

    // a source broadcast in the same cycle as its load counts as ready
    assign new_rdy1 = ready_table[src1] || (wb_valid && (wb_dst == src1));
    assign new_rdy2 = ready_table[src2] || (wb_valid && (wb_dst == src2));

    assign load_age = count - {{`IQ_IDX_W{1'b0}}, take_issue};

    // eligibility; an alu op picked now would land on the bus with the mul picked two ago
    always_comb begin
        for (int i = 0; i < `IQ_ENTRIES; i++) begin
            cand[i] = entries[i].valid && entries[i].rdy1 && entries[i].rdy2
                      && !((op_class(entries[i].op) == CLASS_ALU) && mul_hist[1]);
        end
    end

    // oldest eligible entry, ages are unique among valid entries
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        sel_age   = '1;
        for (int i = 0; i < `IQ_ENTRIES; i++) begin
            if (cand[i] && (!sel_found || (entries[i].age < sel_age))) begin
                sel_found = 1'b1;
                sel_idx   = `IQ_IDX_W'(i);
                sel_age   = entries[i].age;
            end
        end
    end

    assign sel_class = op_class(entries[sel_idx].op);

    // lowest free slot
    always_comb begin
        free_idx = '0;
        for (int i = `IQ_ENTRIES-1; i >= 0; i--) begin
            if (!entries[i].valid) free_idx = `IQ_IDX_W'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `IQ_ENTRIES; i++) begin
                entries[i] <= '0;
            end
            ready_table <= '1;                  // nothing busy after reset
            count       <= '0;
            mul_hist    <= '0;
            issue_valid <= 1'b0;
        end else begin
            for (int i = 0; i < `IQ_ENTRIES; i++) begin
                // wakeup from the result bus
                if (wb_valid && (entries[i].src1 == wb_dst)) entries[i].rdy1 <= 1'b1;
                if (wb_valid && (entries[i].src2 == wb_dst)) entries[i].rdy2 <= 1'b1;
                // entries younger than the issued one move up
                if (take_issue && entries[i].valid && (entries[i].age > sel_age)) begin
                    entries[i].age <= entries[i].age - 1'b1;
                end
            end
            if (take_issue) entries[sel_idx].valid <= 1'b0;
            if (take_load) begin                // free slot is never the selected one
                entries[free_idx] <= '{
                    valid: 1'b1,
                    op:    op,
                    src1:  src1,
                    rdy1:  new_rdy1,
                    src2:  src2,
                    rdy2:  new_rdy2,
                    dst:   dst,
                    age:   load_age[`IQ_IDX_W-1:0]
                };
            end

            // ready table, load of a new dst wins over a broadcast
            if (wb_valid) ready_table[wb_dst] <= 1'b1;
            if (take_load && (dst != '0)) ready_table[dst] <= 1'b0;    // r0 is a discard

            case ({take_load, take_issue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                      // both or neither, occupancy unchanged
            endcase

            mul_hist    <= {mul_hist[0], take_issue && (sel_class == CLASS_MUL)};
            issue_valid <= take_issue;
        end
    end

    // issued payload, qualified by issue_valid
    always_ff @(posedge clk) begin
        if (take_issue) begin
            iss_op    <= entries[sel_idx].op;
            iss_class <= sel_class;
            iss_src1  <= entries[sel_idx].src1;
            iss_src2  <= entries[sel_idx].src2;
            iss_dst   <= entries[sel_idx].dst;
        end
    end

endmodule

/* verilog/sched_pkg.sv */
// issue queue entry struct and writeback source enum
`include "ooo_params.svh"

package sched_pkg;
    import isa_pkg::*;

    // one reservation entry
    typedef struct packed {
        logic                   valid;  // entry occupied
        alu_op_t                op;
        logic [`REG_ADDR_W-1:0] src1;
        logic                   rdy1;   // src1 value is final in the register file
        logic [`REG_ADDR_W-1:0] src2;
        logic                   rdy2;
        logic [`REG_ADDR_W-1:0] dst;
        logic [`IQ_IDX_W-1:0]   age;    // 0 is oldest
    } iq_entry_t;

    // owner of the result bus in a cycle
    typedef enum logic [1:0] {
        WB_NONE = 2'd0,
        WB_ALU  = 2'd1,
        WB_MUL  = 2'd2,
        WB_HOST = 2'd3
    } wb_src_t;

endpackage

/* verilog/isa_pkg.sv */
// opcode enum, opcode class enum and opcode-to-class mapping
package isa_pkg;

    // integer opcodes carried from dispatch to the units
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLT = 3'd5,  // signed compare, 0 or 1
        OP_MUL = 3'd6   // only opcode for the multiplier
    } alu_op_t;

    // which execution unit an opcode goes to
    typedef enum logic {
        CLASS_ALU = 1'b0,
        CLASS_MUL = 1'b1
    } op_class_t;

    function automatic op_class_t op_class(input alu_op_t op);
        return (op == OP_MUL) ? CLASS_MUL : CLASS_ALU;
    endfunction

endpackage

/* verilog/ooo_params.svh */
// queue depth, register count and datapath width defines
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// issue queue sizing
`define IQ_ENTRIES 4   // reservation entries
`define IQ_IDX_W   2   // entry index / age width, log2 of IQ_ENTRIES

// architectural register file
`define REG_NUM    32  // r0 reads as zero
`define REG_ADDR_W 5   // register number width

// datapath
`define DATA_W     16  // operand and result width

`endif
